/* source/flit_buffer_defines.svh */
`ifndef FLIT_BUFFER_DEFINES_SVH
`define FLIT_BUFFER_DEFINES_SVH

// virtual channels sharing one input port
`define FB_NUM_VC     4
// flit slots per vc, keep a power of two so pointers wrap for free
`define FB_VC_SLOTS   4

// flit fields
`define FB_TYPE_W     2
`define FB_PAYLOAD_W  32

// derived widths
`define FB_VC_IDX_W   $clog2(`FB_NUM_VC)
`define FB_PTR_W      $clog2(`FB_VC_SLOTS)
`define FB_DEPTH_W    $clog2(`FB_VC_SLOTS + 1)
// vc index sits above the slot pointer
`define FB_ADDR_W     (`FB_VC_IDX_W + `FB_PTR_W)

`endif

/* source/flit_buffer_pkg.sv */
`include "flit_buffer_defines.svh"

package flit_buffer_pkg;

    // one bit per vc, used for selects and flags
    typedef logic [`FB_NUM_VC-1:0]                vc_onehot_t;
    typedef logic [`FB_VC_IDX_W-1:0]              vc_idx_t;
    typedef logic [`FB_PTR_W-1:0]                 vc_ptr_t;
    // needs one more bit than the pointer to hold a full vc
    typedef logic [`FB_DEPTH_W-1:0]               vc_depth_t;
    typedef logic [`FB_ADDR_W-1:0]                ram_addr_t;
    typedef logic [`FB_TYPE_W-1:0]                flit_type_t;
    typedef logic [`FB_PAYLOAD_W-1:0]             flit_payload_t;
    // stored word, type bits on top
    typedef logic [`FB_TYPE_W+`FB_PAYLOAD_W-1:0]  ram_word_t;

    // one-hot to binary, or of the indices of all set bits
    function automatic vc_idx_t onehot_to_idx(input vc_onehot_t onehot);
        vc_idx_t idx;
        idx = '0;
        for (int i = 0; i < `FB_NUM_VC; i++) begin
            if (onehot[i]) begin
                idx = idx | vc_idx_t'(i);
            end
        end
        return idx;
    endfunction

endpackage

/* source/queue_port_if.sv */
`timescale 1ns/1ps

// address and data path between the pointer banks and the shared ram
interface queue_port_if;

    // write side
    logic                        wr_en;
    flit_buffer_pkg::ram_addr_t  wr_addr;
    flit_buffer_pkg::ram_word_t  wr_data;

    // read side
    logic                        rd_en;
    flit_buffer_pkg::ram_addr_t  rd_addr;

    // write pointer bank only supplies the address
    modport writer (output wr_addr);

    // read pointer bank likewise
    modport reader (output rd_addr);

    // ram sees everything
    modport ram (
        input wr_en,
        input wr_addr,
        input wr_data,
        input rd_en,
        input rd_addr
    );

endinterface

/* source/vc_write_ptrs.sv */
`timescale 1ns/1ps
`include "flit_buffer_defines.svh"

module vc_write_ptrs (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         wr_en,
    // one-hot target vc of the incoming flit
    input  flit_buffer_pkg::vc_onehot_t  vc_num_wr,
    // per-vc write strobe, to the occupancy counters
    output flit_buffer_pkg::vc_onehot_t  wr_strobe,
    queue_port_if.writer                 port
);

    // tail pointer of each vc region
    flit_buffer_pkg::vc_ptr_t  wr_ptr [`FB_NUM_VC];
    flit_buffer_pkg::vc_idx_t  wr_idx;

    // only the selected vc sees the write
    assign wr_strobe = wr_en ? vc_num_wr : '0;

    // slot pointers wrap inside their region
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < `FB_NUM_VC; i++) begin
                wr_ptr[i] <= '0;
            end
        end else begin
            for (int i = 0; i < `FB_NUM_VC; i++) begin
                if (wr_strobe[i]) begin
                    wr_ptr[i] <= flit_buffer_pkg::vc_ptr_t'(wr_ptr[i] + 1'b1);
                end
            end
        end
    end

    // region base from the vc select
    assign wr_idx = flit_buffer_pkg::onehot_to_idx(vc_num_wr);

    // ram address is region index over slot pointer
    assign port.wr_addr = {wr_idx, wr_ptr[wr_idx]};

endmodule

/* source/vc_read_ptrs.sv */
`timescale 1ns/1ps
`include "flit_buffer_defines.svh"

module vc_read_ptrs (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         rd_en,
    // one-hot vc for a normal read
    input  flit_buffer_pkg::vc_onehot_t  vc_num_rd,
    // speculative pops, only honoured while rd_en is low
    input  flit_buffer_pkg::vc_onehot_t  ssa_rd,
    // per-vc read strobe, to the occupancy counters
    output flit_buffer_pkg::vc_onehot_t  rd_strobe,
    queue_port_if.reader                 port
);

    // head pointer of each vc region
    flit_buffer_pkg::vc_ptr_t  rd_ptr [`FB_NUM_VC];
    flit_buffer_pkg::vc_idx_t  rd_idx;

    // normal read wins over ssa
    // the ssa flit itself leaves through the bypass register, not the ram
    assign rd_strobe = rd_en ? vc_num_rd : ssa_rd;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < `FB_NUM_VC; i++) begin
                rd_ptr[i] <= '0;
            end
        end else begin
            // every popped vc moves on, normal or speculative
            for (int i = 0; i < `FB_NUM_VC; i++) begin
                if (rd_strobe[i]) begin
                    rd_ptr[i] <= flit_buffer_pkg::vc_ptr_t'(rd_ptr[i] + 1'b1);
                end
            end
        end
    end

    // address follows vc_num_rd
    // only looked at by the ram when rd_en is high
    assign rd_idx = flit_buffer_pkg::onehot_to_idx(vc_num_rd);

    // region index over head pointer
    assign port.rd_addr = {rd_idx, rd_ptr[rd_idx]};

endmodule

/* source/vc_occupancy.sv */
`timescale 1ns/1ps
`include "flit_buffer_defines.svh"

module vc_occupancy (
    input  logic                         clk,
    input  logic                         reset,
    // strobes from the write pointer bank
    input  flit_buffer_pkg::vc_onehot_t  wr_strobe,
    // strobes from the read pointer bank, ssa included
    input  flit_buffer_pkg::vc_onehot_t  rd_strobe,
    output flit_buffer_pkg::vc_onehot_t  vc_not_empty
);

    // flits held per vc
    flit_buffer_pkg::vc_depth_t  depth [`FB_NUM_VC];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < `FB_NUM_VC; i++) begin
                depth[i] <= '0;
            end
        end else begin
            for (int i = 0; i < `FB_NUM_VC; i++) begin
                // write alone grows the vc
                if (wr_strobe[i] && !rd_strobe[i]) begin
                    depth[i] <= flit_buffer_pkg::vc_depth_t'(depth[i] + 1'b1);
                // read alone shrinks it
                end else if (!wr_strobe[i] && rd_strobe[i]) begin
                    depth[i] <= flit_buffer_pkg::vc_depth_t'(depth[i] - 1'b1);
                end
                // both or neither, depth holds
            end
        end
    end

    // nonzero depth means a flit is waiting
    always_comb begin
        for (int i = 0; i < `FB_NUM_VC; i++) begin
            vc_not_empty[i] = (depth[i] != '0);
        end
    end

endmodule

/* source/flit_queue_ram.sv */
`timescale 1ns/1ps
`include "flit_buffer_defines.svh"

module flit_queue_ram (
    input  logic                        clk,
    input  logic                        reset,
    queue_port_if.ram                   port,
    // registered ram word or bypassed write word
    output flit_buffer_pkg::ram_word_t  rd_data
);

    // one region of slots per vc
    flit_buffer_pkg::ram_word_t  mem [`FB_NUM_VC * `FB_VC_SLOTS];
    flit_buffer_pkg::ram_word_t  mem_q;
    // last cycle's write word, the ssa path
    flit_buffer_pkg::ram_word_t  bypass_q;
    logic                        rd_en_q;

    // synchronous ram, registered read port
    always_ff @(posedge clk) begin
        if (port.wr_en) begin
            mem[port.wr_addr] <= port.wr_data;
        end
        if (port.rd_en) begin
            mem_q <= mem[port.rd_addr];
        end
    end

    // bypass captures the write side every cycle
    // rd_en_q picks the source for this cycle's output
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            bypass_q <= '0;
            rd_en_q  <= 1'b0;
        end else begin
            bypass_q <= port.wr_data;
            rd_en_q  <= port.rd_en;
        end
    end

    // normal read shows the ram word, otherwise the speculative flit
    assign rd_data = rd_en_q ? mem_q : bypass_q;

endmodule

/* source/flit_buffer.sv */
`timescale 1ns/1ps

module flit_buffer (
    input  logic                           clk,
    input  logic                           reset,
    // write side
    input  logic                           wr_en,
    input  flit_buffer_pkg::vc_onehot_t    vc_num_wr,
    input  flit_buffer_pkg::flit_type_t    din_type,
    input  flit_buffer_pkg::flit_payload_t din_payload,
    // read side
    input  logic                           rd_en,
    input  flit_buffer_pkg::vc_onehot_t    vc_num_rd,
    input  flit_buffer_pkg::vc_onehot_t    ssa_rd,
    // flit out, one cycle after the read or bypass
    output flit_buffer_pkg::flit_type_t    dout_type,
    output flit_buffer_pkg::flit_payload_t dout_payload,
    output flit_buffer_pkg::vc_onehot_t    vc_not_empty
);

    flit_buffer_pkg::vc_onehot_t  wr_strobe;
    flit_buffer_pkg::vc_onehot_t  rd_strobe;
    flit_buffer_pkg::ram_word_t   rd_data;

    // shared ram port
    queue_port_if queue_port ();

    // enables and data go straight onto the ram port
    assign queue_port.wr_en   = wr_en;
    assign queue_port.wr_data = {din_type, din_payload};
    assign queue_port.rd_en   = rd_en;

    vc_write_ptrs u_vc_write_ptrs (
        .clk       (clk),
        .reset     (reset),
        .wr_en     (wr_en),
        .vc_num_wr (vc_num_wr),
        .wr_strobe (wr_strobe),
        .port      (queue_port.writer)
    );

    vc_read_ptrs u_vc_read_ptrs (
        .clk       (clk),
        .reset     (reset),
        .rd_en     (rd_en),
        .vc_num_rd (vc_num_rd),
        .ssa_rd    (ssa_rd),
        .rd_strobe (rd_strobe),
        .port      (queue_port.reader)
    );

    // depth bookkeeping from both strobe sets
    vc_occupancy u_vc_occupancy (
        .clk          (clk),
        .reset        (reset),
        .wr_strobe    (wr_strobe),
        .rd_strobe    (rd_strobe),
        .vc_not_empty (vc_not_empty)
    );

    flit_queue_ram u_flit_queue_ram (
        .clk     (clk),
        .reset   (reset),
        .port    (queue_port.ram),
        .rd_data (rd_data)
    );

    // split stored word back into type and payload
    assign {dout_type, dout_payload} = rd_data;

endmodule

/* tb/flit_buffer_checker.sv */
`timescale 1ns/1ps

module flit_buffer_checker (
    input  logic                           clk,
    input  logic                           chk_en,
    input  int                             test_num,
    input  flit_buffer_pkg::flit_type_t    exp_type,
    input  flit_buffer_pkg::flit_payload_t exp_payload,
    input  flit_buffer_pkg::vc_onehot_t    exp_not_empty,
    input  flit_buffer_pkg::flit_type_t    dout_type,
    input  flit_buffer_pkg::flit_payload_t dout_payload,
    input  flit_buffer_pkg::vc_onehot_t    vc_not_empty,
    output int                             test_count,
    output int                             fail_count,
    output int                             check_count,
    output int                             mismatch_count
);

    // test currently being scored, 0 when idle
    int cur_test;
    int test_checks;
    int test_errors;

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        if (actual !== expected) begin
            $display("MISMATCH at %0t ns: %s expected %0h, got %0h",
                     $time, name, expected, actual);
            test_errors++;
            mismatch_count++;
        end
    endtask

    task automatic close_test();
        test_count++;
        if (test_errors != 0) begin
            fail_count++;
        end
        $display("test %0d %s: %0d checks, %0d mismatches", cur_test,
                 (test_errors == 0) ? "passed" : "failed", test_checks, test_errors);
    endtask

    // mid-cycle sample, outputs are all registered
    always @(negedge clk) begin
        // new test number closes the running test
        if (test_num != cur_test) begin
            if (cur_test != 0) begin
                close_test();
            end
            cur_test = test_num;
            test_checks = 0;
            test_errors = 0;
        end
        if (chk_en) begin
            test_checks++;
            check_count++;
            compare_value("dout_type", exp_type, dout_type);
            compare_value("dout_payload", exp_payload, dout_payload);
            compare_value("vc_not_empty", exp_not_empty, vc_not_empty);
        end
    end

endmodule

/* tb/flit_buffer_asserts.sv */
`timescale 1ns/1ps

module flit_buffer_asserts (
    input logic                        clk,
    input logic                        reset,
    input logic                        wr_en,
    input logic                        rd_en,
    input flit_buffer_pkg::vc_onehot_t vc_num_wr,
    input flit_buffer_pkg::vc_onehot_t vc_num_rd,
    input flit_buffer_pkg::vc_onehot_t vc_not_empty
);

    // number of failed assertions so far
    int assert_fails;

    // a write targets exactly one vc
    wr_onehot: assert property (@(posedge clk) disable iff (reset)
        wr_en |-> $onehot(vc_num_wr))
        else begin
            assert_fails++;
            $error("write vc select is not one-hot");
        end

    // same for a normal read
    rd_onehot: assert property (@(posedge clk) disable iff (reset)
        rd_en |-> $onehot(vc_num_rd))
        else begin
            assert_fails++;
            $error("read vc select is not one-hot");
        end

    // no underflow
    rd_not_empty: assert property (@(posedge clk) disable iff (reset)
        rd_en |-> ((vc_num_rd & vc_not_empty) != '0))
        else begin
            assert_fails++;
            $error("normal read from an empty vc");
        end

    // a vc only fills through its own write strobe
    for (genvar i = 0; i < $bits(flit_buffer_pkg::vc_onehot_t); i++) begin : g_rise
        ne_rise: assert property (@(posedge clk) disable iff (reset)
            $rose(vc_not_empty[i]) |-> $past(wr_en && vc_num_wr[i]))
            else begin
                assert_fails++;
                $error("vc %0d became non-empty without a write", i);
            end
    end

endmodule

bind flit_buffer flit_buffer_asserts u_asserts (.*);

/* tb/tb_flit_buffer.sv */
`timescale 1ns/1ps

module tb_flit_buffer;

    localparam int MAX_LINES    = 256;
    localparam int RESET_CYCLES = 3;

    logic                           clk;
    logic                           reset;
    logic                           wr_en;
    flit_buffer_pkg::vc_onehot_t    vc_num_wr;
    flit_buffer_pkg::flit_type_t    din_type;
    flit_buffer_pkg::flit_payload_t din_payload;
    logic                           rd_en;
    flit_buffer_pkg::vc_onehot_t    vc_num_rd;
    flit_buffer_pkg::vc_onehot_t    ssa_rd;
    flit_buffer_pkg::flit_type_t    dout_type;
    flit_buffer_pkg::flit_payload_t dout_payload;
    flit_buffer_pkg::vc_onehot_t    vc_not_empty;

    // expectations of the line driven one cycle earlier
    logic                           chk_en;
    int                             test_num;
    flit_buffer_pkg::flit_type_t    exp_type;
    flit_buffer_pkg::flit_payload_t exp_payload;
    flit_buffer_pkg::vc_onehot_t    exp_not_empty;

    int test_count;
    int fail_count;
    int check_count;
    int mismatch_count;
    int assert_fails;

    // one row per stimulus line with columns in file order
    logic [31:0] stim [MAX_LINES][12];
    int          num_lines;
    int          cycles;
    int          timeout_limit;
    string       load_error;

    initial begin
        clk = 1'b0;
    end

    always #2 clk = ~clk;

    flit_buffer u_flit_buffer (
        .clk          (clk),
        .reset        (reset),
        .wr_en        (wr_en),
        .vc_num_wr    (vc_num_wr),
        .din_type     (din_type),
        .din_payload  (din_payload),
        .rd_en        (rd_en),
        .vc_num_rd    (vc_num_rd),
        .ssa_rd       (ssa_rd),
        .dout_type    (dout_type),
        .dout_payload (dout_payload),
        .vc_not_empty (vc_not_empty)
    );

    flit_buffer_checker u_checker (
        .clk            (clk),
        .chk_en         (chk_en),
        .test_num       (test_num),
        .exp_type       (exp_type),
        .exp_payload    (exp_payload),
        .exp_not_empty  (exp_not_empty),
        .dout_type      (dout_type),
        .dout_payload   (dout_payload),
        .vc_not_empty   (vc_not_empty),
        .test_count     (test_count),
        .fail_count     (fail_count),
        .check_count    (check_count),
        .mismatch_count (mismatch_count)
    );

    task automatic read_stimulus(output string err);
        int    fd;
        int    n;
        string line;
        err = "";
        num_lines = 0;
        fd = $fopen("tb/flit_buffer_stimulus.txt", "r");
        if (fd == 0) begin
            err = "could not open tb/flit_buffer_stimulus.txt";
        end else begin
            while (!$feof(fd) && err == "") begin
                line = "";
                n = $fgets(line, fd);
                // comment and blank lines skipped
                if (n > 1 && line[0] != "#") begin
                    if (num_lines == MAX_LINES) begin
                        err = "stimulus file has too many lines";
                    end else begin
                        n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %d",
                                    stim[num_lines][0], stim[num_lines][1],
                                    stim[num_lines][2], stim[num_lines][3],
                                    stim[num_lines][4], stim[num_lines][5],
                                    stim[num_lines][6], stim[num_lines][7],
                                    stim[num_lines][8], stim[num_lines][9],
                                    stim[num_lines][10], stim[num_lines][11]);
                        if (n != 12) begin
                            err = {"could not parse stimulus line: ", line};
                        end else begin
                            num_lines++;
                        end
                    end
                end
            end
            $fclose(fd);
            if (err == "" && num_lines == 0) begin
                err = "stimulus file holds no lines";
            end
        end
    endtask

    // past the last line the inputs go idle
    task automatic drive_line(input int k);
        if (k < num_lines) begin
            wr_en       = stim[k][0][0];
            vc_num_wr   = flit_buffer_pkg::vc_onehot_t'(stim[k][1]);
            din_type    = flit_buffer_pkg::flit_type_t'(stim[k][2]);
            din_payload = stim[k][3];
            rd_en       = stim[k][4][0];
            vc_num_rd   = flit_buffer_pkg::vc_onehot_t'(stim[k][5]);
            ssa_rd      = flit_buffer_pkg::vc_onehot_t'(stim[k][6]);
        end else begin
            wr_en       = 1'b0;
            vc_num_wr   = '0;
            din_type    = '0;
            din_payload = '0;
            rd_en       = 1'b0;
            vc_num_rd   = '0;
            ssa_rd      = '0;
        end
    endtask

    task automatic expect_line(input int k);
        chk_en        = stim[k][7][0];
        exp_type      = flit_buffer_pkg::flit_type_t'(stim[k][8]);
        exp_payload   = stim[k][9];
        exp_not_empty = flit_buffer_pkg::vc_onehot_t'(stim[k][10]);
        test_num      = int'(stim[k][11]);
    endtask

    // run length guard
    always @(posedge clk) begin
        cycles++;
        if (cycles > timeout_limit) begin
            $display("timeout: run did not finish within %0d cycles", timeout_limit);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    initial begin
        reset         = 1'b1;
        chk_en        = 1'b0;
        test_num      = 0;
        exp_type      = '0;
        exp_payload   = '0;
        exp_not_empty = '0;
        drive_line(MAX_LINES);
        // nonzero write word during reset must not reach the bypass register
        din_type      = '1;
        din_payload   = 32'h5a5a_a5a5;
        read_stimulus(load_error);
        timeout_limit = num_lines + RESET_CYCLES + 20;
        if (load_error != "") begin
            $display("%s", load_error);
            $display("RESULT: FAIL");
            $finish;
        end else begin
            repeat (RESET_CYCLES) @(posedge clk);
            #1;
            reset = 1'b0;
            drive_line(0);
            // reset values show before the first edge samples line 0
            chk_en   = 1'b1;
            test_num = int'(stim[0][11]);
            for (int k = 1; k <= num_lines; k++) begin
                @(posedge clk);
                #1;
                drive_line(k);
                expect_line(k - 1);
            end
            // zero test number closes the last test in the checker
            @(posedge clk);
            #1;
            chk_en = 1'b0;
            test_num = 0;
            @(posedge clk);
            #1;
            assert_fails = u_flit_buffer.u_asserts.assert_fails;
            $display("%0d tests, %0d failed, %0d checks, %0d mismatches, %0d assertion failures",
                     test_count, fail_count, check_count, mismatch_count, assert_fails);
            if (fail_count == 0 && mismatch_count == 0 && assert_fails == 0
                && test_count > 0) begin
                $display("RESULT: PASS");
            end else begin
                $display("RESULT: FAIL");
            end
            $finish;
        end
    end

endmodule

/* project.f */
+incdir+source
source/flit_buffer_pkg.sv
source/queue_port_if.sv
source/vc_write_ptrs.sv
source/vc_read_ptrs.sv
source/vc_occupancy.sv
source/flit_queue_ram.sv
source/flit_buffer.sv
tb/flit_buffer_checker.sv
tb/flit_buffer_asserts.sv
tb/tb_flit_buffer.sv

/* tb/flit_buffer_stimulus.txt */
# wr_en vc_num_wr din_type din_payload rd_en vc_num_rd ssa_rd check exp_type exp_payload exp_ne test
# all hex except the decimal test number, expected values hold one cycle after the line
0 0 0 00000000 0 0 0 1 0 00000000 0 1
1 2 2 a1000001 0 0 0 1 2 a1000001 2 2
1 2 0 a1000002 0 0 0 1 0 a1000002 2 2
1 2 0 a1000003 0 0 0 1 0 a1000003 2 2
1 2 1 a1000004 0 0 0 1 1 a1000004 2 2
0 0 0 00000000 1 2 0 1 2 a1000001 2 2
0 0 0 00000000 1 2 0 1 0 a1000002 2 2
0 0 0 00000000 1 2 0 1 0 a1000003 2 2
0 0 0 00000000 1 2 0 1 1 a1000004 0 2
1 1 2 b0000001 0 0 0 1 2 b0000001 1 3
1 2 2 b1000001 0 0 0 1 2 b1000001 3 3
1 4 2 b2000001 0 0 0 1 2 b2000001 7 3
1 8 2 b3000001 0 0 0 1 2 b3000001 f 3
1 1 1 b0000002 0 0 0 1 1 b0000002 f 3
0 0 0 00000000 1 1 0 1 2 b0000001 f 3
0 0 0 00000000 1 1 0 1 1 b0000002 e 3
0 0 0 00000000 1 2 0 1 2 b1000001 c 3
0 0 0 00000000 1 4 0 1 2 b2000001 8 3
0 0 0 00000000 1 8 0 1 2 b3000001 0 3
1 4 2 c0000001 0 0 0 1 2 c0000001 4 4
1 4 0 c0000002 0 0 0 1 0 c0000002 4 4
1 4 0 c0000003 1 4 0 1 2 c0000001 4 4
1 4 0 c0000004 1 4 0 1 0 c0000002 4 4
1 4 0 c0000005 1 4 0 1 0 c0000003 4 4
1 4 1 c0000006 1 4 0 1 0 c0000004 4 4
0 0 0 00000000 1 4 0 1 0 c0000005 4 4
0 0 0 00000000 1 4 0 1 1 c0000006 0 4
0 0 3 d5a5a5a5 0 0 0 1 3 d5a5a5a5 0 5
1 8 2 e0000001 0 0 8 1 2 e0000001 0 6
1 8 1 e0000002 0 0 0 1 1 e0000002 8 6
0 0 0 00000000 1 8 0 1 1 e0000002 0 6
